//--- compile.f
logic/lsu_isa_pkg.sv
logic/mem_sys_pkg.sv
logic/mem_bus_if.sv
logic/lsu_align.sv
logic/lsu_ctrl_fsm.sv
logic/mem_wait_timer.sv
logic/data_ram.sv
logic/lsu_top.sv
testbench/lsu_tb.sv

//--- logic/data_ram.sv
// Word-addressed data RAM with byte write enables and one cycle of registered read latency
module data_ram (
    input  logic   clk_i,
    mem_bus_if.ram bus_i
);
    import lsu_isa_pkg::*;
    import mem_sys_pkg::*;

    logic [XLEN-1:0]          mem_q [MEM_DEPTH_WORDS];
    logic [MEM_ADDR_BITS-1:0] word_idx;
    logic                     commit;

    // Byte offset bits are dropped, the word index sits just above them
    assign word_idx = bus_i.addr[OFFSET_BITS +: MEM_ADDR_BITS];

    assign commit = bus_i.sel && !bus_i.stall;

    always_ff @(posedge clk_i) begin
        if (commit) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (bus_i.we && bus_i.mask[lane]) begin
                    mem_q[word_idx][lane * BYTE_WIDTH +: BYTE_WIDTH] <=
                        bus_i.wdata[lane * BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
            // A store reads back the old word, nobody uses it
            bus_i.rdata <= mem_q[word_idx];
        end
    end

endmodule

//--- logic/lsu_align.sv
// LSU datapath: aligns store data and byte mask onto the bus and extends the returned load word
module lsu_align (
    input  logic                         clk_i,
    input  lsu_isa_pkg::lsu_op_e         op_i,
    input  logic [lsu_isa_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_isa_pkg::XLEN-1:0] wdata_i,
    output logic [lsu_isa_pkg::XLEN-1:0] result_o,
    mem_bus_if.lsu                       bus_io
);
    import lsu_isa_pkg::*;

    logic [OFFSET_BITS-1:0] offset;
    lsu_op_e                op_q;
    logic [OFFSET_BITS-1:0] offset_q;
    logic [BYTE_WIDTH-1:0]  load_byte;
    logic [HALF_WIDTH-1:0]  load_half;

    assign offset = addr_i[OFFSET_BITS-1:0];

    // Low bits only pick the lanes, the bus always sees a word address
    assign bus_io.addr = {addr_i[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    always_comb begin
        case (op_i)
            LSU_SB: begin
                bus_io.wdata = XLEN'(wdata_i[BYTE_WIDTH-1:0]) << (BYTE_WIDTH * offset);
                bus_io.mask  = BYTE_LANES'(1) << offset;
            end
            LSU_SH: begin
                bus_io.wdata = XLEN'(wdata_i[HALF_WIDTH-1:0]) << (HALF_WIDTH * offset[1]);
                bus_io.mask  = BYTE_LANES'(2'b11) << (2 * offset[1]);
            end
            default: begin
                // SW and every load use the whole word
                bus_io.wdata = wdata_i;
                bus_io.mask  = {BYTE_LANES{1'b1}};
            end
        endcase
    end

    // The last sel cycle of an access is the completing one, so these
    // values line up with the read word that the RAM registers
    always_ff @(posedge clk_i) begin
        if (bus_io.sel) begin
            op_q     <= op_i;
            offset_q <= offset;
        end
    end

    assign load_byte = bus_io.rdata[BYTE_WIDTH * offset_q +: BYTE_WIDTH];
    assign load_half = bus_io.rdata[HALF_WIDTH * offset_q[1] +: HALF_WIDTH];

    always_comb begin
        case (op_q)
            LSU_LB: begin
                result_o = {{(XLEN - BYTE_WIDTH){load_byte[BYTE_WIDTH-1]}}, load_byte};
            end
            LSU_LBU: begin
                result_o = {{(XLEN - BYTE_WIDTH){1'b0}}, load_byte};
            end
            LSU_LH: begin
                result_o = {{(XLEN - HALF_WIDTH){load_half[HALF_WIDTH-1]}}, load_half};
            end
            LSU_LHU: begin
                result_o = {{(XLEN - HALF_WIDTH){1'b0}}, load_half};
            end
            default: begin
                // LW passes the word through, stores leave it meaningless
                result_o = bus_io.rdata;
            end
        endcase
    end

endmodule

//--- logic/lsu_ctrl_fsm.sv
// Access controller: takes a start strobe, raises the bus request until the memory completes, pulses done
module lsu_ctrl_fsm (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  logic                 hold_i,
    input  lsu_isa_pkg::lsu_op_e op_i,
    output logic                 done_o,
    mem_bus_if.ctrl              bus_o
);
    import lsu_isa_pkg::*;
    import mem_sys_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        req;
    logic        is_store;

    assign is_store = op_i inside {LSU_SB, LSU_SH, LSU_SW};

    // A pipeline hold drops the request for that cycle only
    assign req = (state_q == CTRL_ACCESS) && !hold_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (start_i) begin
                    state_d = CTRL_ACCESS;
                end
            end
            CTRL_ACCESS: begin
                // The memory commits in the first requested cycle without stall
                if (req && !bus_o.stall) begin
                    state_d = CTRL_DONE;
                end
            end
            CTRL_DONE: begin
                state_d = CTRL_IDLE;
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign bus_o.sel = req;
    assign bus_o.we  = req && is_store;

    // The extended load word is on the RAM output during this one cycle
    assign done_o = (state_q == CTRL_DONE);

endmodule

//--- logic/lsu_isa_pkg.sv
// Core-side load/store definitions: operation encoding and data widths, imported by the LSU blocks
package lsu_isa_pkg;

    // Data and address width of the core
    localparam int XLEN = 32;

    // Bytes per word, also the width of the byte mask
    localparam int BYTE_LANES = 4;

    localparam int BYTE_WIDTH = 8;
    localparam int HALF_WIDTH = 2 * BYTE_WIDTH;

    // Address bits that select a byte inside a word
    localparam int OFFSET_BITS = $clog2(BYTE_LANES);

    // Loads come first, stores occupy the top three codes
    typedef enum logic [2:0] {
        LSU_LB  = 3'd0,
        LSU_LH  = 3'd1,
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,
        LSU_LHU = 3'd4,
        LSU_SB  = 3'd5,
        LSU_SH  = 3'd6,
        LSU_SW  = 3'd7
    } lsu_op_e;

endpackage

//--- logic/lsu_top.sv
// Load/store path top level: controller, wait timer, LSU datapath and data RAM on one memory bus
module lsu_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         start_i,
    input  logic                         hold_i,
    input  lsu_isa_pkg::lsu_op_e         op_i,
    input  logic [lsu_isa_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_isa_pkg::XLEN-1:0] wdata_i,
    output logic                         done_o,
    output logic [lsu_isa_pkg::XLEN-1:0] result_o
);

    mem_bus_if bus ();

    // Sequences each request and owns sel and we
    lsu_ctrl_fsm i_ctrl (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (start_i),
        .hold_i  (hold_i),
        .op_i    (op_i),
        .done_o  (done_o),
        .bus_o   (bus.ctrl)
    );

    mem_wait_timer i_timer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus_i   (bus.timer)
    );

    // Lane steering for stores and extension for loads
    lsu_align i_align (
        .clk_i    (clk_i),
        .op_i     (op_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .result_o (result_o),
        .bus_io   (bus.lsu)
    );

    data_ram i_ram (
        .clk_i (clk_i),
        .bus_i (bus.ram)
    );

endmodule

//--- logic/mem_bus_if.sv
// Data memory bus shared by the controller, the wait timer, the LSU datapath and the RAM
interface mem_bus_if;
    import lsu_isa_pkg::*;

    // Request level and write enable from the controller
    logic                  sel;
    logic                  we;

    // Word-aligned address, aligned store data and byte lanes from the LSU
    logic [XLEN-1:0]       addr;
    logic [XLEN-1:0]       wdata;
    logic [BYTE_LANES-1:0] mask;

    // Registered read word from the RAM
    logic [XLEN-1:0]       rdata;

    // High while the memory still inserts wait states
    logic                  stall;

    modport ctrl (output sel, output we, input stall);

    modport lsu (output addr, output wdata, output mask, input sel, input rdata);

    modport timer (input sel, output stall);

    // The RAM only commits a cycle once the wait states are over
    modport ram (
        input  sel, we, addr, wdata, mask, stall,
        output rdata
    );

endinterface

//--- logic/mem_sys_pkg.sv
// Memory-side definitions: RAM size, wait states and controller states for the access path
package mem_sys_pkg;

    // Data RAM geometry in words
    localparam int MEM_DEPTH_WORDS = 256;
    localparam int MEM_ADDR_BITS   = $clog2(MEM_DEPTH_WORDS);

    // Extra cycles the memory needs before an access may complete
    localparam int MEM_WAIT_CYCLES = 2;

    // Wide enough to hold MEM_WAIT_CYCLES, at least one bit
    localparam int WAIT_CNT_BITS = $clog2(MEM_WAIT_CYCLES + 2);

    typedef enum logic [1:0] {
        CTRL_IDLE   = 2'd0,
        CTRL_ACCESS = 2'd1,
        CTRL_DONE   = 2'd2
    } ctrl_state_e;

endpackage

//--- logic/mem_wait_timer.sv
// Wait-state timer: stalls each bus access for a fixed number of requested cycles before it completes
module mem_wait_timer (
    input  logic     clk_i,
    input  logic     rst_n_i,
    mem_bus_if.timer bus_i
);
    import mem_sys_pkg::*;

    logic [WAIT_CNT_BITS-1:0] count_q;
    logic                     waiting;

    assign waiting = count_q < WAIT_CNT_BITS'(MEM_WAIT_CYCLES);

    // Only requested cycles are stalled
    assign bus_i.stall = bus_i.sel && waiting;

    // Cycles without sel neither count nor reload, so a held access
    // resumes where it stopped
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (bus_i.sel) begin
            if (waiting) begin
                count_q <= count_q + 1'b1;
            end else begin
                // Saturated and requested, the access completes now
                count_q <= '0;
            end
        end
    end

endmodule

//--- testbench/lsu_tb.sv
// Testbench for lsu_top that runs a table of loads and stores against a shadow memory model
module lsu_tb;
    import lsu_isa_pkg::*;
    import mem_sys_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int MAX_HOLD     = 3;
    localparam int MARGIN       = 20;

    // Random accesses stay inside a small window of eight words
    localparam logic [XLEN-1:0] RAND_BASE  = 32'h0000_0200;
    localparam int              RAND_WORDS = 8;
    localparam int              RAND_MIXED = 24;

    typedef struct {
        string           name;
        lsu_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        int              hold;
        bit              busy;
        logic [XLEN-1:0] exp;
    } test_entry_t;

    logic            clk_i;
    logic            rst_n_i;
    logic            start_i;
    logic            hold_i;
    lsu_op_e         op_i;
    logic [XLEN-1:0] addr_i;
    logic [XLEN-1:0] wdata_i;
    logic            done_o;
    logic [XLEN-1:0] result_o;

    test_entry_t     tests[$];
    logic [XLEN-1:0] shadow_mem [MEM_DEPTH_WORDS];
    logic [31:0]     lcg_state = 32'h6e52;
    int              cycle_count = 0;
    int              cycle_limit = 0;

    lsu_top i_dut (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (start_i),
        .hold_i   (hold_i),
        .op_i     (op_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .done_o   (done_o),
        .result_o (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("TIMEOUT: done_o never arrived within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit is_store_op(input lsu_op_e op);
        return (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
    endfunction

    function automatic logic [XLEN-1:0] predict_load(input lsu_op_e op,
                                                     input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        logic [7:0]      b;
        logic [15:0]     h;
        word = shadow_mem[addr[OFFSET_BITS +: MEM_ADDR_BITS]];
        b = 8'(word >> (8 * addr[1:0]));
        h = 16'(word >> (16 * addr[1]));
        case (op)
            LSU_LB:  return {{(XLEN - 8){b[7]}}, b};
            LSU_LBU: return {{(XLEN - 8){1'b0}}, b};
            LSU_LH:  return {{(XLEN - 16){h[15]}}, h};
            LSU_LHU: return {{(XLEN - 16){1'b0}}, h};
            default: return word;
        endcase
    endfunction

    // Merges a store into the shadow word with a keep mask
    task automatic update_shadow(input lsu_op_e op, input logic [XLEN-1:0] addr,
                                 input logic [XLEN-1:0] wdata);
        logic [MEM_ADDR_BITS-1:0] idx;
        logic [XLEN-1:0]          keep;
        logic [XLEN-1:0]          ins;
        idx = addr[OFFSET_BITS +: MEM_ADDR_BITS];
        case (op)
            LSU_SB: begin
                keep = ~(32'h0000_00ff << (8 * addr[1:0]));
                ins  = XLEN'(wdata[7:0]) << (8 * addr[1:0]);
            end
            LSU_SH: begin
                keep = ~(32'h0000_ffff << (16 * addr[1]));
                ins  = XLEN'(wdata[15:0]) << (16 * addr[1]);
            end
            default: begin
                keep = '0;
                ins  = wdata;
            end
        endcase
        shadow_mem[idx] = (shadow_mem[idx] & keep) | ins;
    endtask

    // Expected values are predicted in table order while the table is built
    task automatic add_entry(input string name, input lsu_op_e op,
                             input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                             input int hold, input bit busy);
        test_entry_t t;
        t.name  = name;
        t.op    = op;
        t.addr  = addr;
        t.wdata = wdata;
        t.hold  = hold;
        t.busy  = busy;
        t.exp   = 'x;
        if (is_store_op(op)) begin
            update_shadow(op, addr, wdata);
        end else begin
            t.exp = predict_load(op, addr);
        end
        tests.push_back(t);
    endtask

    task automatic build_table();
        lsu_op_e         rop;
        logic [XLEN-1:0] raddr;
        add_entry("sw_word", LSU_SW, 32'h10, 32'h1234_5678, 0, 0);
        add_entry("lw_word", LSU_LW, 32'h10, 32'h0, 0, 0);
        add_entry("sw_base", LSU_SW, 32'h20, 32'hdead_beef, 0, 0);
        add_entry("sb_off1", LSU_SB, 32'h21, 32'hffff_ff5a, 0, 0);
        add_entry("lw_after_sb1", LSU_LW, 32'h20, 32'h0, 0, 0);
        add_entry("sb_off0", LSU_SB, 32'h20, 32'h0000_0011, 0, 0);
        add_entry("sb_off2", LSU_SB, 32'h22, 32'h0000_0033, 0, 0);
        add_entry("sb_off3", LSU_SB, 32'h23, 32'h0000_0044, 0, 0);
        add_entry("lw_after_sb", LSU_LW, 32'h20, 32'h0, 0, 0);
        // Bytes 01, ff, 7f and 80 give both sign bit values
        add_entry("sw_signs", LSU_SW, 32'h30, 32'h807f_ff01, 0, 0);
        for (int off = 0; off < BYTE_LANES; off++) begin
            add_entry($sformatf("lb_off%0d", off), LSU_LB, 32'h30 + off, 32'h0, 0, 0);
            add_entry($sformatf("lbu_off%0d", off), LSU_LBU, 32'h30 + off, 32'h0, 0, 0);
        end
        add_entry("sh_off0", LSU_SH, 32'h40, 32'hffff_8001, 0, 0);
        add_entry("sh_off2", LSU_SH, 32'h42, 32'h0000_7ffe, 0, 0);
        add_entry("lh_off0", LSU_LH, 32'h40, 32'h0, 0, 0);
        add_entry("lhu_off0", LSU_LHU, 32'h40, 32'h0, 0, 0);
        add_entry("lh_off2", LSU_LH, 32'h42, 32'h0, 0, 0);
        add_entry("lhu_off2", LSU_LHU, 32'h42, 32'h0, 0, 0);
        add_entry("lw_halves", LSU_LW, 32'h40, 32'h0, 0, 0);
        add_entry("lw_hold1_busy", LSU_LW, 32'h10, 32'h0, 1, 1);
        add_entry("sw_hold3_busy", LSU_SW, 32'h50, 32'hcafe_f00d, 3, 1);
        add_entry("lw_hold3", LSU_LW, 32'h50, 32'h0, 3, 0);
        // Fill the random window first so that every random load reads known data
        for (int w = 0; w < RAND_WORDS; w++) begin
            lcg_state = lcg_next(lcg_state);
            add_entry($sformatf("rand_fill%0d", w), LSU_SW, RAND_BASE + 4 * w, lcg_state, 0, 0);
        end
        for (int i = 0; i < RAND_MIXED; i++) begin
            lcg_state = lcg_next(lcg_state);
            rop   = lsu_op_e'(lcg_state[30:28]);
            raddr = RAND_BASE + XLEN'(lcg_state[20:16]);
            lcg_state = lcg_next(lcg_state);
            add_entry($sformatf("rand_%0d", i), rop, raddr, lcg_state,
                      int'(lcg_state[25:24]), lcg_state[11]);
        end
    endtask

    task automatic check_result(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s latency: expected %0d, actual %0d", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Hold starts after one requested cycle so the wait count must pause mid-access
    // The busy start pulse lands in the second access cycle
    task automatic run_entry(input test_entry_t t);
        int cycles;
        cycles  = 0;
        op_i    = t.op;
        addr_i  = t.addr;
        wdata_i = t.wdata;
        hold_i  = 1'b0;
        start_i = 1'b1;
        do begin
            @(posedge clk_i);
            #1;
            cycles++;
            hold_i  = (cycles >= 2) && (cycles <= t.hold + 1);
            start_i = t.busy && (cycles == 2);
        end while (!done_o);
        check_latency(t.name, MEM_WAIT_CYCLES + 2 + t.hold, cycles);
        if (!is_store_op(t.op)) begin
            check_result(t.name, t.exp, result_o);
        end
        @(posedge clk_i);
        #1;
        check_level({t.name, " done pulse"}, 1'b0, done_o);
    endtask

    initial begin
        rst_n_i = 1'b0;
        start_i = 1'b0;
        hold_i  = 1'b0;
        op_i    = LSU_LW;
        addr_i  = '0;
        wdata_i = '0;
        build_table();
        cycle_limit = tests.size() * (MEM_WAIT_CYCLES + 2 + MAX_HOLD) + RESET_CYCLES + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        check_level("reset done", 1'b0, done_o);
        foreach (tests[i]) begin
            run_entry(tests[i]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule
